/* common/graph_pkg.sv */
package graph_pkg;

	////////////////////////////////////////
	// Sizing
	////////////////////////////////////////

	localparam int NUM_VERTEX_CU     = 4;
	localparam int CU_ID_BITS        = 2;
	localparam int RESULT_FIFO_DEPTH = 8;

	typedef logic [15:0]           vertex_id_t;
	typedef logic [23:0]           edge_index_t;
	typedef logic [31:0]           address_t;
	typedef logic [31:0]           value_t;
	typedef logic [CU_ID_BITS-1:0] cu_id_t;

	////////////////////////////////////////
	// Bus and job records
	////////////////////////////////////////

	typedef struct packed {
		address_t edge_array_base;
		address_t result_base;
	} graph_config_t;

	typedef struct packed {
		logic        valid;
		vertex_id_t  vertex_id;
		edge_index_t edge_start;
		edge_index_t edge_count;
	} vertex_job_t;

	typedef struct packed {
		logic     valid;
		address_t address;
		cu_id_t   cu_id;
	} read_command_t;

	// Tag in cu_id names the unit that issued the read
	typedef struct packed {
		logic   valid;
		cu_id_t cu_id;
		value_t data;
	} read_response_t;

	typedef struct packed {
		logic        valid;
		vertex_id_t  vertex_id;
		edge_index_t edge_count;
		value_t      sum;
	} vertex_result_t;

	typedef struct packed {
		logic     valid;
		address_t address;
		value_t   data;
	} write_command_t;

	typedef struct packed {
		logic empty;
		logic full;
	} buffer_status_t;

	typedef enum logic [2:0] {
		CU_IDLE,
		CU_JOB_REQUEST,
		CU_READ_ISSUE,
		CU_READ_WAIT,
		CU_RESULT_POST
	} cu_state_t;

endpackage

/* compute_unit/vertex_compute_unit.sv */
`timescale 1ns/1ps

module vertex_compute_unit (
	input  logic                       clock,
	input  logic                       rstn,
	input  logic                       enabled,
	input  graph_pkg::graph_config_t   graph_config,
	input  logic                       job_grant,
	output logic                       job_request,
	input  graph_pkg::vertex_job_t     vertex_job,
	input  logic                       read_grant,
	output logic                       read_request,
	output graph_pkg::address_t        read_address,
	input  graph_pkg::read_response_t  read_response,
	input  logic                       result_grant,
	output logic                       result_request,
	output graph_pkg::vertex_result_t  result
);

	graph_pkg::cu_state_t   state;
	graph_pkg::vertex_job_t job;
	graph_pkg::edge_index_t issued;
	graph_pkg::edge_index_t returned;
	graph_pkg::value_t      sum;
	logic                   job_granted;

	// Request lines follow the state, grants come back in the same cycle
	assign job_request    = (state == graph_pkg::CU_JOB_REQUEST) && !job_granted;
	assign read_request   = (state == graph_pkg::CU_READ_ISSUE);
	assign result_request = (state == graph_pkg::CU_RESULT_POST);

	// Edge k of the job lives at base + start + k
	assign read_address = graph_config.edge_array_base
		+ graph_pkg::address_t'(job.edge_start)
		+ graph_pkg::address_t'(issued);

	always_comb begin
		result.valid      = (state == graph_pkg::CU_RESULT_POST);
		result.vertex_id  = job.vertex_id;
		result.edge_count = job.edge_count;
		result.sum        = sum;
	end

	////////////////////////////////////////
	// Control FSM
	////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state       <= graph_pkg::CU_IDLE;
			job_granted <= 1'b0;
			issued      <= '0;
			returned    <= '0;
		end else begin
			// Responses may land while reads are still going out
			if (read_response.valid)
				returned <= graph_pkg::edge_index_t'(returned + 1'b1);
			case (state)
				graph_pkg::CU_IDLE: begin
					if (enabled)
						state <= graph_pkg::CU_JOB_REQUEST;
				end
				graph_pkg::CU_JOB_REQUEST: begin
					if (job_grant)
						job_granted <= 1'b1;
					if (vertex_job.valid) begin
						job_granted <= 1'b0;
						issued      <= '0;
						returned    <= '0;
						if (vertex_job.edge_count == '0)
							state <= graph_pkg::CU_RESULT_POST;
						else
							state <= graph_pkg::CU_READ_ISSUE;
					end
				end
				graph_pkg::CU_READ_ISSUE: begin
					if (read_grant) begin
						issued <= graph_pkg::edge_index_t'(issued + 1'b1);
						if (graph_pkg::edge_index_t'(issued + 1'b1) == job.edge_count)
							state <= graph_pkg::CU_READ_WAIT;
					end
				end
				graph_pkg::CU_READ_WAIT: begin
					if (returned == job.edge_count)
						state <= graph_pkg::CU_RESULT_POST;
				end
				graph_pkg::CU_RESULT_POST: begin
					if (result_grant)
						state <= graph_pkg::CU_IDLE;
				end
				default: state <= graph_pkg::CU_IDLE;
			endcase
		end
	end

	// Job record and running sum
	always_ff @(posedge clock) begin
		if (state == graph_pkg::CU_JOB_REQUEST && vertex_job.valid) begin
			job <= vertex_job;
			sum <= '0;
		end else if (read_response.valid) begin
			sum <= sum + read_response.data;
		end
	end

	// Arbiter routing must never hand a response to an idle unit
	assert property (@(posedge clock) disable iff (!rstn)
		read_response.valid |-> state != graph_pkg::CU_IDLE);

	assert property (@(posedge clock) disable iff (!rstn) returned <= issued);

endmodule

/* logic/cu_arbiter.sv */
`timescale 1ns/1ps

module cu_arbiter (
	input  logic                                clock,
	input  logic                                rstn,
	input  logic                                enabled,
	input  logic [graph_pkg::NUM_VERTEX_CU-1:0] job_request_cu,
	output logic [graph_pkg::NUM_VERTEX_CU-1:0] job_grant_cu,
	output logic                                vertex_job_request,
	input  graph_pkg::vertex_job_t              vertex_job,
	output graph_pkg::vertex_job_t              vertex_job_cu [graph_pkg::NUM_VERTEX_CU],
	input  logic [graph_pkg::NUM_VERTEX_CU-1:0] read_request_cu,
	input  graph_pkg::address_t                 read_address_cu [graph_pkg::NUM_VERTEX_CU],
	output logic [graph_pkg::NUM_VERTEX_CU-1:0] read_grant_cu,
	input  graph_pkg::buffer_status_t           read_buffer_status,
	output graph_pkg::read_command_t            read_command,
	input  graph_pkg::read_response_t           read_response,
	output graph_pkg::read_response_t           read_response_cu [graph_pkg::NUM_VERTEX_CU],
	input  logic [graph_pkg::NUM_VERTEX_CU-1:0] result_request_cu,
	input  graph_pkg::vertex_result_t           result_cu [graph_pkg::NUM_VERTEX_CU],
	output logic [graph_pkg::NUM_VERTEX_CU-1:0] result_grant_cu,
	input  graph_pkg::buffer_status_t           fifo_status,
	output graph_pkg::vertex_result_t           fifo_push
);

	graph_pkg::cu_id_t job_ptr, read_ptr, result_ptr;
	graph_pkg::cu_id_t job_winner, read_winner, result_winner;
	graph_pkg::cu_id_t job_owner;
	logic              job_pending;

	// Nearest requester at or after ptr wins
	function automatic logic [graph_pkg::NUM_VERTEX_CU-1:0] rr_pick(
		input logic [graph_pkg::NUM_VERTEX_CU-1:0] req,
		input graph_pkg::cu_id_t                   ptr
	);
		logic [graph_pkg::NUM_VERTEX_CU-1:0] grant;
		graph_pkg::cu_id_t                   idx;
		grant = '0;
		for (int k = graph_pkg::NUM_VERTEX_CU - 1; k >= 0; k--) begin
			idx = graph_pkg::cu_id_t'(ptr + graph_pkg::cu_id_t'(k));
			if (req[idx]) begin
				grant      = '0;
				grant[idx] = 1'b1;
			end
		end
		return grant;
	endfunction

	function automatic graph_pkg::cu_id_t to_id(input logic [graph_pkg::NUM_VERTEX_CU-1:0] grant);
		graph_pkg::cu_id_t id;
		id = '0;
		for (int k = 0; k < graph_pkg::NUM_VERTEX_CU; k++)
			if (grant[k])
				id = graph_pkg::cu_id_t'(k);
		return id;
	endfunction

	// A registered push still in flight counts as occupied
	always_comb begin
		job_grant_cu    = (enabled && !job_pending) ? rr_pick(job_request_cu, job_ptr) : '0;
		read_grant_cu   = (enabled && !read_buffer_status.full) ?
			rr_pick(read_request_cu, read_ptr) : '0;
		result_grant_cu = (enabled && !fifo_status.full && !fifo_push.valid) ?
			rr_pick(result_request_cu, result_ptr) : '0;
		job_winner      = to_id(job_grant_cu);
		read_winner     = to_id(read_grant_cu);
		result_winner   = to_id(result_grant_cu);
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			job_ptr            <= '0;
			read_ptr           <= '0;
			result_ptr         <= '0;
			job_owner          <= '0;
			job_pending        <= 1'b0;
			vertex_job_request <= 1'b0;
			read_command       <= '0;
			fifo_push          <= '0;
			for (int i = 0; i < graph_pkg::NUM_VERTEX_CU; i++) begin
				vertex_job_cu[i]    <= '0;
				read_response_cu[i] <= '0;
			end
		end else begin
			vertex_job_request <= |job_grant_cu;
			if (vertex_job.valid)
				job_pending <= 1'b0;
			if (|job_grant_cu) begin
				job_pending <= 1'b1;
				job_owner   <= job_winner;
				job_ptr     <= graph_pkg::cu_id_t'(job_winner + 1'b1);
			end

			read_command.valid   <= |read_grant_cu;
			read_command.address <= read_address_cu[read_winner];
			read_command.cu_id   <= read_winner;
			if (|read_grant_cu)
				read_ptr <= graph_pkg::cu_id_t'(read_winner + 1'b1);

			fifo_push       <= result_cu[result_winner];
			fifo_push.valid <= |result_grant_cu;
			if (|result_grant_cu)
				result_ptr <= graph_pkg::cu_id_t'(result_winner + 1'b1);

			// Steer the returning job and tagged responses
			for (int i = 0; i < graph_pkg::NUM_VERTEX_CU; i++) begin
				vertex_job_cu[i]          <= vertex_job;
				vertex_job_cu[i].valid    <= vertex_job.valid && job_pending &&
					job_owner == graph_pkg::cu_id_t'(i);
				read_response_cu[i]       <= read_response;
				read_response_cu[i].valid <= read_response.valid &&
					read_response.cu_id == graph_pkg::cu_id_t'(i);
			end
		end
	end

	assert property (@(posedge clock) disable iff (!rstn)
		$onehot0(job_grant_cu) && $onehot0(read_grant_cu) && $onehot0(result_grant_cu));

endmodule

/* logic/result_fifo.sv */
`timescale 1ns/1ps

module result_fifo (
	input  logic                      clock,
	input  logic                      rstn,
	input  graph_pkg::vertex_result_t push,
	input  logic                      pop,
	output graph_pkg::vertex_result_t result_out,
	output graph_pkg::buffer_status_t status
);

	graph_pkg::vertex_result_t mem [graph_pkg::RESULT_FIFO_DEPTH];

	logic [$clog2(graph_pkg::RESULT_FIFO_DEPTH)-1:0] rd_ptr;
	logic [$clog2(graph_pkg::RESULT_FIFO_DEPTH)-1:0] wr_idx;
	logic [$clog2(graph_pkg::RESULT_FIFO_DEPTH):0]   count;

	// Write slot sits count entries past the head, wrapping on depth
	assign wr_idx = rd_ptr + count[$clog2(graph_pkg::RESULT_FIFO_DEPTH)-1:0];

	assign status.empty = (count == '0);
	assign status.full  = (count == graph_pkg::RESULT_FIFO_DEPTH);

	always_comb begin
		result_out       = mem[rd_ptr];
		result_out.valid = !status.empty;
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push.valid, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (push.valid)
			mem[wr_idx] <= push;
	end

	// Arbiter holds result grants off while a push is still pending
	assert property (@(posedge clock) disable iff (!rstn) push.valid |-> !status.full);

	assert property (@(posedge clock) disable iff (!rstn) pop |-> !status.empty);

endmodule

/* logic/edge_data_write_control.sv */
`timescale 1ns/1ps

module edge_data_write_control (
	input  logic                      clock,
	input  logic                      rstn,
	input  graph_pkg::graph_config_t  graph_config,
	input  graph_pkg::vertex_result_t result_in,
	input  graph_pkg::buffer_status_t fifo_status,
	input  graph_pkg::buffer_status_t write_buffer_status,
	output logic                      pop,
	output graph_pkg::write_command_t write_command,
	output graph_pkg::vertex_id_t     vertex_job_counter_done,
	output graph_pkg::edge_index_t    edge_job_counter_done
);

	// One result leaves the FIFO per write that goes out
	assign pop = !fifo_status.empty && !write_buffer_status.full;

	////////////////////////////////////////
	// Write command and done counters
	////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			write_command           <= '0;
			vertex_job_counter_done <= '0;
			edge_job_counter_done   <= '0;
		end else begin
			write_command.valid   <= pop;
			write_command.address <= graph_config.result_base
				+ graph_pkg::address_t'(result_in.vertex_id);
			write_command.data    <= result_in.sum;
			if (pop) begin
				vertex_job_counter_done <= vertex_job_counter_done + 1'b1;
				edge_job_counter_done   <= edge_job_counter_done + result_in.edge_count;
			end
		end
	end

endmodule

/* logic/graph_algorithm_control.sv */
`timescale 1ns/1ps

module graph_algorithm_control (
	input  logic                      clock,
	input  logic                      rstn,
	input  logic                      enabled_in,
	input  graph_pkg::graph_config_t  config_in,
	input  graph_pkg::vertex_job_t    vertex_job,
	output logic                      vertex_job_request,
	input  graph_pkg::read_response_t read_response_in,
	input  graph_pkg::buffer_status_t read_buffer_status,
	output graph_pkg::read_command_t  read_command_out,
	input  graph_pkg::buffer_status_t write_buffer_status,
	output graph_pkg::write_command_t write_command_out,
	output graph_pkg::vertex_id_t     vertex_job_counter_done,
	output graph_pkg::edge_index_t    edge_job_counter_done
);

	logic                      enabled;
	graph_pkg::graph_config_t  config_latched;
	graph_pkg::vertex_job_t    vertex_job_latched;
	graph_pkg::read_response_t read_response_latched;
	graph_pkg::buffer_status_t read_buffer_status_latched;
	graph_pkg::buffer_status_t write_buffer_status_latched;

	logic                      vertex_job_request_arb;
	graph_pkg::read_command_t  read_command_arb;
	graph_pkg::write_command_t write_command_wc;
	graph_pkg::vertex_id_t     vertex_counter_wc;
	graph_pkg::edge_index_t    edge_counter_wc;

	logic [graph_pkg::NUM_VERTEX_CU-1:0] job_request_cu, job_grant_cu;
	logic [graph_pkg::NUM_VERTEX_CU-1:0] read_request_cu, read_grant_cu;
	logic [graph_pkg::NUM_VERTEX_CU-1:0] result_request_cu, result_grant_cu;

	graph_pkg::vertex_job_t    vertex_job_cu    [graph_pkg::NUM_VERTEX_CU];
	graph_pkg::address_t       read_address_cu  [graph_pkg::NUM_VERTEX_CU];
	graph_pkg::read_response_t read_response_cu [graph_pkg::NUM_VERTEX_CU];
	graph_pkg::vertex_result_t result_cu        [graph_pkg::NUM_VERTEX_CU];

	graph_pkg::vertex_result_t fifo_push, fifo_out;
	graph_pkg::buffer_status_t fifo_status;
	logic                      fifo_pop;

	////////////////////////////////////////
	// Enable, input and output registers
	////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			enabled <= 1'b0;
		else
			enabled <= enabled_in;
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			config_latched              <= '0;
			vertex_job_latched          <= '0;
			read_response_latched       <= '0;
			read_buffer_status_latched  <= '{empty: 1'b1, full: 1'b0};
			write_buffer_status_latched <= '{empty: 1'b1, full: 1'b0};
		end else if (enabled) begin
			vertex_job_latched          <= vertex_job;
			read_response_latched       <= read_response_in;
			read_buffer_status_latched  <= read_buffer_status;
			write_buffer_status_latched <= write_buffer_status;
			// Keep the last nonzero configuration
			if (|config_in)
				config_latched <= config_in;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			vertex_job_request      <= 1'b0;
			read_command_out        <= '0;
			write_command_out       <= '0;
			vertex_job_counter_done <= '0;
			edge_job_counter_done   <= '0;
		end else begin
			vertex_job_request      <= vertex_job_request_arb;
			read_command_out        <= read_command_arb;
			write_command_out       <= write_command_wc;
			vertex_job_counter_done <= vertex_counter_wc;
			edge_job_counter_done   <= edge_counter_wc;
		end
	end

	////////////////////////////////////////
	// Compute units
	////////////////////////////////////////

	generate
		for (genvar i = 0; i < graph_pkg::NUM_VERTEX_CU; i++) begin : gen_vertex_cu
			vertex_compute_unit vertex_compute_unit_i (
				.clock         (clock),
				.rstn          (rstn),
				.enabled       (enabled),
				.graph_config  (config_latched),
				.job_grant     (job_grant_cu[i]),
				.job_request   (job_request_cu[i]),
				.vertex_job    (vertex_job_cu[i]),
				.read_grant    (read_grant_cu[i]),
				.read_request  (read_request_cu[i]),
				.read_address  (read_address_cu[i]),
				.read_response (read_response_cu[i]),
				.result_grant  (result_grant_cu[i]),
				.result_request(result_request_cu[i]),
				.result        (result_cu[i])
			);
		end
	endgenerate

	cu_arbiter cu_arbiter_i (
		.clock             (clock),
		.rstn              (rstn),
		.enabled           (enabled),
		.job_request_cu    (job_request_cu),
		.job_grant_cu      (job_grant_cu),
		.vertex_job_request(vertex_job_request_arb),
		.vertex_job        (vertex_job_latched),
		.vertex_job_cu     (vertex_job_cu),
		.read_request_cu   (read_request_cu),
		.read_address_cu   (read_address_cu),
		.read_grant_cu     (read_grant_cu),
		.read_buffer_status(read_buffer_status_latched),
		.read_command      (read_command_arb),
		.read_response     (read_response_latched),
		.read_response_cu  (read_response_cu),
		.result_request_cu (result_request_cu),
		.result_cu         (result_cu),
		.result_grant_cu   (result_grant_cu),
		.fifo_status       (fifo_status),
		.fifo_push         (fifo_push)
	);

	result_fifo result_fifo_i (
		.clock     (clock),
		.rstn      (rstn),
		.push      (fifo_push),
		.pop       (fifo_pop),
		.result_out(fifo_out),
		.status    (fifo_status)
	);

	edge_data_write_control edge_data_write_control_i (
		.clock                  (clock),
		.rstn                   (rstn),
		.graph_config           (config_latched),
		.result_in              (fifo_out),
		.fifo_status            (fifo_status),
		.write_buffer_status    (write_buffer_status_latched),
		.pop                    (fifo_pop),
		.write_command          (write_command_wc),
		.vertex_job_counter_done(vertex_counter_wc),
		.edge_job_counter_done  (edge_counter_wc)
	);

endmodule

/* bench/memory_model.sv */
`timescale 1ns/1ps

module memory_model (
	input  logic                      clock,
	input  logic                      rstn,
	input  graph_pkg::read_command_t  read_command,
	output graph_pkg::read_response_t read_response
);

	localparam int SLOTS = 32;

	int                  seed  = 11488;
	int                  cycle = 0;
	logic                busy [SLOTS];
	int                  due  [SLOTS];
	graph_pkg::cu_id_t   tag  [SLOTS];
	graph_pkg::address_t addr [SLOTS];
	logic                placed;
	int                  start;
	int                  pick;
	int                  idx;

	// Fixed mix of the address, the same one the testbench sums up
	function automatic graph_pkg::value_t mem_value(input graph_pkg::address_t address);
		return (address * 32'h9e37_79b1) ^ {address[15:0], address[31:16]} ^ 32'h5a5a_0f0f;
	endfunction

	initial begin
		read_response = '0;
		for (int i = 0; i < SLOTS; i++)
			busy[i] = 1'b0;
		forever begin
			@(posedge clock);
			#2;
			cycle++;
			read_response = '0;
			if (!rstn) begin
				for (int i = 0; i < SLOTS; i++)
					busy[i] = 1'b0;
			end else begin
				// Park the new read with a latency of 1 to 8 cycles
				if (read_command.valid) begin
					placed = 1'b0;
					for (int i = 0; i < SLOTS; i++) begin
						if (!placed && !busy[i]) begin
							busy[i] = 1'b1;
							tag[i]  = read_command.cu_id;
							addr[i] = read_command.address;
							due[i]  = cycle + 1 + int'($unsigned($random(seed)) % 8);
							placed  = 1'b1;
						end
					end
				end
				// Random scan start, so ready reads leave out of order
				start = int'($unsigned($random(seed)) % SLOTS);
				pick  = -1;
				for (int k = 0; k < SLOTS; k++) begin
					idx = (start + k) % SLOTS;
					if (pick < 0 && busy[idx] && due[idx] <= cycle)
						pick = idx;
				end
				if (pick >= 0) begin
					read_response.valid = 1'b1;
					read_response.cu_id = tag[pick];
					read_response.data  = mem_value(addr[pick]);
					busy[pick]          = 1'b0;
				end
			end
		end
	end

endmodule

/* bench/graph_algorithm_control_tb.sv */
`timescale 1ns/1ps

module graph_algorithm_control_tb;

	localparam int NUM_JOBS    = 24;
	localparam int MAX_EDGES   = 6;
	localparam int CLOCK_NS    = 20;
	localparam int RESET_CYCLES = 5;
	localparam int IDLE_CYCLES = 10;
	// 12 cycles per edge plus 40 cycles of overhead for every job
	localparam int TIMEOUT_NS  = NUM_JOBS * (MAX_EDGES * 12 + 40) * CLOCK_NS
		+ (RESET_CYCLES + IDLE_CYCLES) * CLOCK_NS;

	localparam graph_pkg::address_t EDGE_BASE   = 32'h0010_0000;
	localparam graph_pkg::address_t RESULT_BASE = 32'h0080_0000;

	logic                      clock = 1'b0;
	logic                      rstn;
	logic                      enabled_in;
	graph_pkg::graph_config_t  config_in;
	graph_pkg::vertex_job_t    vertex_job;
	logic                      vertex_job_request;
	graph_pkg::read_response_t read_response_in;
	graph_pkg::buffer_status_t read_buffer_status;
	graph_pkg::read_command_t  read_command_out;
	graph_pkg::buffer_status_t write_buffer_status;
	graph_pkg::write_command_t write_command_out;
	graph_pkg::vertex_id_t     vertex_job_counter_done;
	graph_pkg::edge_index_t    edge_job_counter_done;

	graph_pkg::vertex_job_t job_table [NUM_JOBS];
	int   job_of_vertex [65536];
	int   read_count [NUM_JOBS] = '{default: 0};
	logic written [NUM_JOBS]    = '{default: 1'b0};
	int   seed         = 11488;
	int   jobs_handed  = 0;
	int   job_wait     = 0;
	int   writes_seen  = 0;
	int   total_edges  = 0;
	logic stress       = 1'b0;
	logic [2:0] full_history = '0;

	graph_algorithm_control graph_algorithm_control_i (
		.clock                  (clock),
		.rstn                   (rstn),
		.enabled_in             (enabled_in),
		.config_in              (config_in),
		.vertex_job             (vertex_job),
		.vertex_job_request     (vertex_job_request),
		.read_response_in       (read_response_in),
		.read_buffer_status     (read_buffer_status),
		.read_command_out       (read_command_out),
		.write_buffer_status    (write_buffer_status),
		.write_command_out      (write_command_out),
		.vertex_job_counter_done(vertex_job_counter_done),
		.edge_job_counter_done  (edge_job_counter_done)
	);

	memory_model memory_model_i (
		.clock        (clock),
		.rstn         (rstn),
		.read_command (read_command_out),
		.read_response(read_response_in)
	);

	always #(CLOCK_NS / 2) clock = ~clock;

	////////////////////////////////////////
	// Reference model
	////////////////////////////////////////

	function automatic graph_pkg::value_t mem_value(input graph_pkg::address_t address);
		return (address * 32'h9e37_79b1) ^ {address[15:0], address[31:16]} ^ 32'h5a5a_0f0f;
	endfunction

	function automatic graph_pkg::value_t expected_sum(input graph_pkg::vertex_job_t job);
		graph_pkg::value_t sum;
		sum = '0;
		for (int k = 0; k < int'(job.edge_count); k++)
			sum = sum + mem_value(EDGE_BASE + graph_pkg::address_t'(job.edge_start)
				+ graph_pkg::address_t'(k));
		return sum;
	endfunction

	task automatic build_job_table();
		graph_pkg::vertex_id_t id;
		int                    start;
		start = 0;
		for (int i = 0; i < 65536; i++)
			job_of_vertex[i] = -1;
		for (int j = 0; j < NUM_JOBS; j++) begin
			do
				id = graph_pkg::vertex_id_t'($random(seed));
			while (job_of_vertex[id] >= 0);
			job_table[j].valid      = 1'b1;
			job_table[j].vertex_id  = id;
			job_table[j].edge_start = graph_pkg::edge_index_t'(start);
			// Job 5 always has no edges
			job_table[j].edge_count = (j == 5) ? '0 :
				graph_pkg::edge_index_t'($unsigned($random(seed)) % (MAX_EDGES + 1));
			// One spare slot after every job keeps edge ranges apart
			start             = start + int'(job_table[j].edge_count) + 1;
			total_edges       = total_edges + int'(job_table[j].edge_count);
			job_of_vertex[id] = j;
		end
	endtask

	////////////////////////////////////////
	// Checks
	////////////////////////////////////////

	task automatic end_with_failure();
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic compare_flag(input string name, input logic actual, input logic expected);
		if (actual !== expected) begin
			$display("FAIL %0t %s: got %b expected %b", $time, name, actual, expected);
			end_with_failure();
		end
	endtask

	task automatic compare_write(input string name, input graph_pkg::write_command_t actual,
		input graph_pkg::write_command_t expected);
		if (actual !== expected) begin
			$display("FAIL %0t %s: got address %h data %h, expected address %h data %h",
				$time, name, actual.address, actual.data, expected.address, expected.data);
			end_with_failure();
		end
	endtask

	task automatic compare_count(input graph_pkg::vertex_id_t vertices,
		input graph_pkg::vertex_id_t expected_vertices, input graph_pkg::edge_index_t edges,
		input graph_pkg::edge_index_t expected_edges);
		if (vertices !== expected_vertices) begin
			$display("FAIL %0t vertex_job_counter_done: got %0d expected %0d",
				$time, vertices, expected_vertices);
			end_with_failure();
		end else if (edges !== expected_edges) begin
			$display("FAIL %0t edge_job_counter_done: got %0d expected %0d",
				$time, edges, expected_edges);
			end_with_failure();
		end
	endtask

	// A read must hit the edges of a job that was already handed out
	task automatic check_read(input graph_pkg::address_t address);
		graph_pkg::address_t first;
		int                  owner;
		owner = -1;
		for (int j = 0; j < jobs_handed; j++) begin
			first = EDGE_BASE + graph_pkg::address_t'(job_table[j].edge_start);
			if (address >= first && address < first + graph_pkg::address_t'(job_table[j].edge_count))
				owner = j;
		end
		if (owner < 0) begin
			$display("ERROR: read of address %h at %0t hits no edge of a handed-out job",
				address, $time);
			end_with_failure();
		end else begin
			read_count[owner]++;
		end
	endtask

	// Reads counted over all jobs
	function automatic int total_reads();
		int total;
		total = 0;
		for (int j = 0; j < NUM_JOBS; j++)
			total = total + read_count[j];
		return total;
	endfunction

	task automatic check_write(input graph_pkg::write_command_t command);
		graph_pkg::address_t       offset;
		graph_pkg::write_command_t expected;
		int                        j;
		offset = command.address - RESULT_BASE;
		j      = (offset < 32'h0001_0000) ? job_of_vertex[offset[15:0]] : -1;
		if (j < 0 || j >= jobs_handed) begin
			$display("ERROR: write to address %h at %0t belongs to no known job",
				command.address, $time);
			end_with_failure();
		end else if (written[j]) begin
			$display("ERROR: vertex %0d was written a second time at %0t",
				job_table[j].vertex_id, $time);
			end_with_failure();
		end else if (read_count[j] != int'(job_table[j].edge_count)) begin
			$display("ERROR: vertex %0d saw %0d reads for %0d edges", job_table[j].vertex_id,
				read_count[j], job_table[j].edge_count);
			end_with_failure();
		end else begin
			expected.valid   = 1'b1;
			expected.address = RESULT_BASE + graph_pkg::address_t'(job_table[j].vertex_id);
			expected.data    = expected_sum(job_table[j]);
			compare_write("write_command_out", command, expected);
			written[j] = 1'b1;
			writes_seen++;
		end
	endtask

	// Outputs are stable at the falling edge
	always @(negedge clock) begin
		if (rstn) begin
			// Full at the port reaches read_command_out three cycles later
			if (read_command_out.valid && full_history[2]) begin
				$display("ERROR: read command at %0t despite a full read buffer", $time);
				end_with_failure();
			end
			if (read_command_out.valid)
				check_read(read_command_out.address);
			if (write_command_out.valid)
				check_write(write_command_out);
			full_history = {full_history[1:0], read_buffer_status.full};
		end
	end

	////////////////////////////////////////
	// Job source and back-pressure
	////////////////////////////////////////

	initial begin
		vertex_job          = '0;
		read_buffer_status  = '{empty: 1'b1, full: 1'b0};
		write_buffer_status = '{empty: 1'b1, full: 1'b0};
		build_job_table();
		forever begin
			@(posedge clock);
			#2;
			vertex_job = '0;
			if (job_wait > 0) begin
				job_wait--;
				if (job_wait == 0 && jobs_handed < NUM_JOBS) begin
					vertex_job = job_table[jobs_handed];
					jobs_handed++;
				end
			end
			if (rstn && vertex_job_request)
				job_wait = 1 + int'($unsigned($random(seed)) % 4);
			read_buffer_status.full   = stress && ($unsigned($random(seed)) % 4) == 0;
			read_buffer_status.empty  = !read_buffer_status.full;
			write_buffer_status.full  = stress && ($unsigned($random(seed)) % 3) == 0;
			write_buffer_status.empty = !write_buffer_status.full;
		end
	end

	initial begin
		#(TIMEOUT_NS);
		$display("ERROR: timeout after %0t with %0d of %0d vertex results written",
			$time, writes_seen, NUM_JOBS);
		end_with_failure();
	end

	initial begin
		rstn       = 1'b0;
		enabled_in = 1'b0;
		config_in  = '{edge_array_base: EDGE_BASE, result_base: RESULT_BASE};
		repeat (RESET_CYCLES) @(posedge clock);
		#2;
		rstn = 1'b1;

		// Nothing moves while enabled_in is low
		repeat (IDLE_CYCLES) begin
			@(negedge clock);
			compare_flag("read_command_out.valid", read_command_out.valid, 1'b0);
			compare_flag("write_command_out.valid", write_command_out.valid, 1'b0);
			compare_flag("vertex_job_request", vertex_job_request, 1'b0);
			compare_count(vertex_job_counter_done, '0, edge_job_counter_done, '0);
		end

		@(posedge clock);
		#2;
		enabled_in = 1'b1;
		repeat (4) @(posedge clock);
		#2;
		// The latched configuration must survive a zero one
		config_in = '0;
		@(negedge clock);
		stress = 1'b1;

		wait (writes_seen == NUM_JOBS);
		stress = 1'b0;
		repeat (4) @(negedge clock);
		compare_count(vertex_job_counter_done, graph_pkg::vertex_id_t'(NUM_JOBS),
			edge_job_counter_done, graph_pkg::edge_index_t'(total_edges));
		if (total_reads() == total_edges) begin
			$display("Simulation passed");
			$finish;
		end else begin
			$display("ERROR: %0d edge reads seen for %0d edges", total_reads(),
				total_edges);
			end_with_failure();
		end
	end

endmodule

/* graph_algorithm_control.f */
common/graph_pkg.sv
compute_unit/vertex_compute_unit.sv
logic/cu_arbiter.sv
logic/result_fifo.sv
logic/edge_data_write_control.sv
logic/graph_algorithm_control.sv
bench/memory_model.sv
bench/graph_algorithm_control_tb.sv

/* Makefile */
TB_TOP := graph_algorithm_control_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f graph_algorithm_control.f \
		--top-module graph_algorithm_control

sim:
	verilator --binary --timing --assert -f graph_algorithm_control.f \
		--top-module $(TB_TOP) -o $(TB_TOP)
	./obj_dir/$(TB_TOP) | tee sim.log
	grep -q "Simulation passed" sim.log

clean:
	rm -rf obj_dir sim.log
